/* cacheCfgPkg.sv */
`default_nettype none

package cacheCfgPkg;

	// geometry of the data cache
	localparam int TagWidth = 26;
	localparam int IndexWidth = 3;
	localparam int NumSets = 8; // 2**IndexWidth
	localparam int WordsPerBlock = 2;
	localparam int NumWays = 2;

	typedef logic [TagWidth-1:0] tagT;
	typedef logic [IndexWidth-1:0] indexT;

	// miss handling walks these in order, Idle is the only state that answers the cpu
	typedef enum logic [2:0] {
		Idle,
		WriteBack0, // victim word 0 out to memory
		WriteBack1,
		Fill0, // requested block word 0 in from memory
		Fill1
	} ctrlStateT;

endpackage

`default_nettype wire

/* cpuTypesPkg.sv */
`default_nettype none

package cpuTypesPkg;

	typedef logic [31:0] wordT;

	// field split of a data address, msb first
	typedef struct packed {
		cacheCfgPkg::tagT tag;
		cacheCfgPkg::indexT index;
		logic wordSel; // word within the block
		logic [1:0] byteOff; // always zero for word accesses
	} dAddrFieldsT;

	// same 32 bits seen flat or split into fields
	typedef union packed {
		wordT flat;
		dAddrFieldsT fields;
	} dAddrT;

endpackage

`default_nettype wire

/* dcacheWay.sv */
`timescale 1ns/1ps
`default_nettype none

module dcacheWay (
	input logic CLK,
	input logic nRST,
	input cacheCfgPkg::indexT index,
	input logic wordSel,
	input cpuTypesPkg::wordT writeData,
	input cacheCfgPkg::tagT writeTag,
	input logic writeDirty,
	input logic dataWen,
	input logic metaWen,
	output cacheCfgPkg::tagT readTag,
	output logic readValid,
	output logic readDirty,
	output cpuTypesPkg::wordT readData
);
	import cpuTypesPkg::*;
	import cacheCfgPkg::*;

	// one entry per set
	logic [NumSets-1:0] validBits;
	logic [NumSets-1:0] dirtyBits;
	tagT tags [NumSets];
	wordT data [NumSets][WordsPerBlock];

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			validBits <= '0;
			dirtyBits <= '0;
			for (int s = 0; s < NumSets; s++) begin
				tags[s] <= '0;
				for (int w = 0; w < WordsPerBlock; w++) begin
					data[s][w] <= '0;
				end
			end
		end else begin
			if (dataWen) begin
				data[index][wordSel] <= writeData;
			end
			// tag update always marks the entry present
			if (metaWen) begin
				tags[index] <= writeTag;
				dirtyBits[index] <= writeDirty;
				validBits[index] <= 1'b1;
			end
		end
	end

	// combinational read of the addressed set
	assign readTag = tags[index];
	assign readValid = validBits[index];
	assign readDirty = dirtyBits[index];
	assign readData = data[index][wordSel];

endmodule

`default_nettype wire

/* dcacheCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dcacheCtrl (
	input logic CLK,
	input logic nRST,
	// cpu side
	input logic dmemREN,
	input logic dmemWEN,
	input cpuTypesPkg::dAddrT dmemAddr,
	input cpuTypesPkg::wordT dmemStore,
	output cpuTypesPkg::wordT dmemLoad,
	output logic dhit,
	// memory side
	output logic dREN,
	output logic dWEN,
	output cpuTypesPkg::wordT dAddr,
	output cpuTypesPkg::wordT dStore,
	input cpuTypesPkg::wordT dLoad,
	input logic dwait,
	// write bus shared by both ways
	output cacheCfgPkg::indexT index,
	output logic wordSel,
	output cpuTypesPkg::wordT writeData,
	output cacheCfgPkg::tagT writeTag,
	output logic writeDirty,
	output logic dataWen0,
	output logic metaWen0,
	output logic dataWen1,
	output logic metaWen1,
	// way read results
	input cacheCfgPkg::tagT readTag0,
	input logic readValid0,
	input logic readDirty0,
	input cpuTypesPkg::wordT readData0,
	input cacheCfgPkg::tagT readTag1,
	input logic readValid1,
	input logic readDirty1,
	input cpuTypesPkg::wordT readData1
);
	import cpuTypesPkg::*;
	import cacheCfgPkg::*;

	ctrlStateT state;
	ctrlStateT nextState;
	logic [NumSets-1:0] lru; // names the way to evict next
	logic [NumWays-1:0] hitVec;
	logic [NumWays-1:0] dataWenVec;
	logic [NumWays-1:0] metaWenVec;
	logic req;
	logic hit;
	logic hitWay;
	logic victim;
	tagT victimTag;
	logic victimValid;
	logic victimDirty;
	wordT victimData;
	tagT reqTag;
	indexT reqIndex;
	logic inWriteBack;
	logic inFill;
	dAddrT memAddr;

	// split the request address
	assign reqTag = dmemAddr.fields.tag;
	assign reqIndex = dmemAddr.fields.index;
	assign req = dmemREN | dmemWEN;

	assign hitVec[0] = readValid0 && (readTag0 == reqTag);
	assign hitVec[1] = readValid1 && (readTag1 == reqTag);
	assign hit = |hitVec;
	assign hitWay = hitVec[1]; // both ways never hold the same tag

	assign victim = lru[reqIndex];
	assign victimTag = victim ? readTag1 : readTag0;
	assign victimValid = victim ? readValid1 : readValid0;
	assign victimDirty = victim ? readDirty1 : readDirty0;
	assign victimData = victim ? readData1 : readData0;

	assign inWriteBack = (state == WriteBack0) || (state == WriteBack1);
	assign inFill = (state == Fill0) || (state == Fill1);

	// hits only answered from Idle
	assign dhit = (state == Idle) && req && hit;
	assign dmemLoad = hitWay ? readData1 : readData0;

	assign index = reqIndex;

	always_comb begin
		case (state)
			WriteBack0, Fill0: wordSel = 1'b0;
			WriteBack1, Fill1: wordSel = 1'b1;
			default: wordSel = dmemAddr.fields.wordSel;
		endcase
	end

	assign writeData = inFill ? dLoad : dmemStore;
	assign writeTag = reqTag;
	assign writeDirty = (state == Idle); // set by a write hit, cleared by the fill

	always_comb begin
		dataWenVec = '0;
		metaWenVec = '0;
		if (dhit && dmemWEN) begin
			dataWenVec[hitWay] = 1'b1;
			metaWenVec[hitWay] = 1'b1;
		end else if (inFill && !dwait) begin
			dataWenVec[victim] = 1'b1;
			metaWenVec[victim] = (state == Fill1); // tag goes in with the last word
		end
	end

	assign dataWen0 = dataWenVec[0];
	assign metaWen0 = metaWenVec[0];
	assign dataWen1 = dataWenVec[1];
	assign metaWen1 = metaWenVec[1];

	// memory address, victim tag while writing back
	always_comb begin
		memAddr.fields.tag = inWriteBack ? victimTag : reqTag;
		memAddr.fields.index = reqIndex;
		memAddr.fields.wordSel = wordSel;
		memAddr.fields.byteOff = 2'b00;
	end

	assign dAddr = memAddr.flat;
	assign dStore = victimData;
	assign dWEN = inWriteBack;
	assign dREN = inFill;

	always_comb begin
		nextState = state;
		case (state)
			Idle: begin
				if (req && !hit) begin
					nextState = (victimValid && victimDirty) ? WriteBack0 : Fill0;
				end
			end
			WriteBack0: begin
				if (!dwait) begin
					nextState = WriteBack1;
				end
			end
			WriteBack1: begin
				if (!dwait) begin
					nextState = Fill0;
				end
			end
			Fill0: begin
				if (!dwait) begin
					nextState = Fill1;
				end
			end
			Fill1: begin
				if (!dwait) begin
					nextState = Idle; // retried there as a hit
				end
			end
			default: nextState = Idle;
		endcase
	end

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			state <= Idle;
			lru <= '0;
		end else begin
			state <= nextState;
			if (dhit) begin
				lru[reqIndex] <= ~hitWay; // point at the other way
			end
		end
	end

endmodule

`default_nettype wire

/* dcacheTop.sv */
`timescale 1ns/1ps
`default_nettype none

module dcacheTop (
	input logic CLK,
	input logic nRST,
	// cpu side
	input logic dmemREN,
	input logic dmemWEN,
	input cpuTypesPkg::dAddrT dmemAddr,
	input cpuTypesPkg::wordT dmemStore,
	output cpuTypesPkg::wordT dmemLoad,
	output logic dhit,
	// memory side
	output logic dREN,
	output logic dWEN,
	output cpuTypesPkg::wordT dAddr,
	output cpuTypesPkg::wordT dStore,
	input cpuTypesPkg::wordT dLoad,
	input logic dwait
);
	import cpuTypesPkg::*;
	import cacheCfgPkg::*;

	// shared write bus
	indexT index;
	logic wordSel;
	wordT writeData;
	tagT writeTag;
	logic writeDirty;

	// per way
	logic dataWen0;
	logic metaWen0;
	logic dataWen1;
	logic metaWen1;
	tagT readTag0;
	tagT readTag1;
	logic readValid0;
	logic readValid1;
	logic readDirty0;
	logic readDirty1;
	wordT readData0;
	wordT readData1;

	dcacheCtrl ctrl (
		.CLK(CLK),
		.nRST(nRST),
		.dmemREN(dmemREN),
		.dmemWEN(dmemWEN),
		.dmemAddr(dmemAddr),
		.dmemStore(dmemStore),
		.dmemLoad(dmemLoad),
		.dhit(dhit),
		.dREN(dREN),
		.dWEN(dWEN),
		.dAddr(dAddr),
		.dStore(dStore),
		.dLoad(dLoad),
		.dwait(dwait),
		.index(index),
		.wordSel(wordSel),
		.writeData(writeData),
		.writeTag(writeTag),
		.writeDirty(writeDirty),
		.dataWen0(dataWen0),
		.metaWen0(metaWen0),
		.dataWen1(dataWen1),
		.metaWen1(metaWen1),
		.readTag0(readTag0),
		.readValid0(readValid0),
		.readDirty0(readDirty0),
		.readData0(readData0),
		.readTag1(readTag1),
		.readValid1(readValid1),
		.readDirty1(readDirty1),
		.readData1(readData1)
	);

	dcacheWay way0 (
		.CLK(CLK),
		.nRST(nRST),
		.index(index),
		.wordSel(wordSel),
		.writeData(writeData),
		.writeTag(writeTag),
		.writeDirty(writeDirty),
		.dataWen(dataWen0),
		.metaWen(metaWen0),
		.readTag(readTag0),
		.readValid(readValid0),
		.readDirty(readDirty0),
		.readData(readData0)
	);

	dcacheWay way1 (
		.CLK(CLK),
		.nRST(nRST),
		.index(index),
		.wordSel(wordSel),
		.writeData(writeData),
		.writeTag(writeTag),
		.writeDirty(writeDirty),
		.dataWen(dataWen1),
		.metaWen(metaWen1),
		.readTag(readTag1),
		.readValid(readValid1),
		.readDirty(readDirty1),
		.readData(readData1)
	);

endmodule

`default_nettype wire

/* tbMainMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMainMemory (
	input logic CLK,
	input logic nRST,
	input logic dREN,
	input logic dWEN,
	input cpuTypesPkg::wordT dAddr,
	input cpuTypesPkg::wordT dStore,
	output cpuTypesPkg::wordT dLoad,
	output logic dwait
);
	import cpuTypesPkg::*;

	localparam int Depth = 1024; // word slots, picked by address bits 11:2
	localparam int LogDepth = 64;

	logic written [Depth];
	wordT storedAddr [Depth]; // full address kept so aliases fall back to the pattern
	wordT storedData [Depth];
	wordT logAddr [LogDepth]; // write log, read by the testbench
	wordT logData [LogDepth];
	int logCount;
	logic [31:0] lcgState;
	int waitLeft;

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// unwritten words read as their address xor a fixed mask
	always_comb begin
		if (written[dAddr[11:2]] && storedAddr[dAddr[11:2]] == dAddr) begin
			dLoad = storedData[dAddr[11:2]];
		end else begin
			dLoad = dAddr ^ 32'hA5A5A5A5;
		end
	end

	assign dwait = (waitLeft != 0);

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			lcgState <= 32'h429d3a0e;
			waitLeft <= 0;
			logCount <= 0;
			for (int i = 0; i < Depth; i++) begin
				written[i] <= 1'b0;
			end
		end else if (dREN || dWEN) begin
			if (waitLeft != 0) begin
				waitLeft <= waitLeft - 1;
			end else begin
				if (dWEN) begin
					written[dAddr[11:2]] <= 1'b1;
					storedAddr[dAddr[11:2]] <= dAddr;
					storedData[dAddr[11:2]] <= dStore;
					if (logCount < LogDepth) begin
						logAddr[logCount] <= dAddr;
						logData[logCount] <= dStore;
					end
					logCount <= logCount + 1;
				end
				lcgState <= lcgNext(lcgState);
				waitLeft <= int'(lcgState[17:16]); // 0 to 3 wait cycles for the next word
			end
		end
	end

endmodule

`default_nettype wire

/* dcacheTb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcacheTb;
	import cpuTypesPkg::*;

	localparam int MaxSteps = 32;
	localparam int WaitLimit = 100; // cycles allowed for one access

	logic CLK = 1'b0;
	logic nRST;
	logic dmemREN;
	logic dmemWEN;
	dAddrT dmemAddr;
	wordT dmemStore;
	wordT dmemLoad;
	logic dhit;
	logic dREN;
	logic dWEN;
	wordT dAddr;
	wordT dStore;
	wordT dLoad;
	logic dwait;

	// step table
	string stepName [MaxSteps];
	logic stepWrite [MaxSteps];
	wordT stepAddr [MaxSteps];
	wordT stepData [MaxSteps];
	logic stepTraffic [MaxSteps]; // memory traffic expected before dhit
	logic stepEvict [MaxSteps]; // dirty victim goes back to memory
	wordT stepVictim [MaxSteps];
	int numSteps = 0;

	wordT refData [1024]; // expected value of each word below 4K

	always #2 CLK = ~CLK;

	dcacheTop dut (.*);
	tbMainMemory mem (.*);

	task automatic abortRun();
		$display("Test failures found");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic checkWord(input string name, input wordT exp, input wordT act);
		if (exp !== act) begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
			abortRun();
		end
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("CHECK FAILED %s expected %b actual %b", name, exp, act);
			abortRun();
		end
	endtask

	task automatic checkAddr(input string name, input dAddrT exp, input dAddrT act);
		if (exp !== act) begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp.flat, act.flat);
			abortRun();
		end
	endtask

	task automatic addStep(input string name, input logic isWrite, input wordT addr,
		input wordT data, input logic traffic, input logic evict, input wordT victim);
		stepName[numSteps] = name;
		stepWrite[numSteps] = isWrite;
		stepAddr[numSteps] = addr;
		stepData[numSteps] = data;
		stepTraffic[numSteps] = traffic;
		stepEvict[numSteps] = evict;
		stepVictim[numSteps] = victim;
		numSteps++;
	endtask

	task automatic runStep(input int i);
		int cycles;
		int logStart;
		logic sawRead;
		logic sawWrite;
		dAddrT victimAddr;
		dAddrT logged;
		@(negedge CLK);
		dmemREN = !stepWrite[i];
		dmemWEN = stepWrite[i];
		dmemAddr.flat = stepAddr[i];
		dmemStore = stepData[i];
		logStart = mem.logCount;
		cycles = 0;
		sawRead = 1'b0;
		sawWrite = 1'b0;
		#1;
		while (!dhit) begin
			sawRead |= dREN;
			sawWrite |= dWEN;
			cycles++;
			if (cycles > WaitLimit) begin
				$display("timeout: no dhit for step %s within %0d cycles",
					stepName[i], WaitLimit);
				abortRun();
			end
			@(negedge CLK);
			#1;
		end
		if (!stepWrite[i]) begin
			checkWord({stepName[i], " load"}, refData[stepAddr[i][11:2]], dmemLoad);
		end
		checkBit({stepName[i], " traffic"}, stepTraffic[i], sawRead | sawWrite);
		checkBit({stepName[i], " dWEN"}, stepEvict[i], sawWrite);
		@(negedge CLK);
		dmemREN = 1'b0;
		dmemWEN = 1'b0;
		if (stepWrite[i]) begin
			refData[stepAddr[i][11:2]] = stepData[i]; // write hit took effect at last edge
		end
		checkWord({stepName[i], " log size"}, wordT'(logStart + (stepEvict[i] ? 2 : 0)),
			wordT'(mem.logCount));
		if (stepEvict[i]) begin
			for (int w = 0; w < 2; w++) begin
				victimAddr.flat = stepVictim[i];
				victimAddr.fields.wordSel = w[0];
				victimAddr.fields.byteOff = 2'b00;
				logged.flat = mem.logAddr[logStart + w];
				checkAddr({stepName[i], " wb addr"}, victimAddr, logged);
				checkWord({stepName[i], " wb data"}, refData[victimAddr.flat[11:2]],
					mem.logData[logStart + w]);
			end
		end
	endtask

	initial begin
		nRST = 1'b0;
		dmemREN = 1'b0;
		dmemWEN = 1'b0;
		dmemAddr = '0;
		dmemStore = '0;
		for (int i = 0; i < 1024; i++) begin
			refData[i] = wordT'(i * 4) ^ 32'hA5A5A5A5;
		end
		// name, write, address, store data, traffic, dirty eviction, victim block
		addStep("read miss", 0, 32'h010, 32'h0, 1, 0, 32'h0);
		addStep("read hit", 0, 32'h010, 32'h0, 0, 0, 32'h0);
		addStep("read hit neighbor", 0, 32'h014, 32'h0, 0, 0, 32'h0);
		addStep("write hit", 1, 32'h014, 32'hDEADBEEF, 0, 0, 32'h0);
		addStep("read back", 0, 32'h014, 32'h0, 0, 0, 32'h0);
		addStep("write miss", 1, 32'h020, 32'h12345678, 1, 0, 32'h0);
		addStep("neighbor from memory", 0, 32'h024, 32'h0, 0, 0, 32'h0);
		addStep("written word", 0, 32'h020, 32'h0, 0, 0, 32'h0);
		addStep("lru A", 0, 32'h008, 32'h0, 1, 0, 32'h0);
		addStep("lru B", 0, 32'h048, 32'h0, 1, 0, 32'h0);
		addStep("lru A again", 0, 32'h008, 32'h0, 0, 0, 32'h0);
		addStep("lru C clean evict", 0, 32'h088, 32'h0, 1, 0, 32'h0);
		addStep("lru A kept", 0, 32'h00C, 32'h0, 0, 0, 32'h0);
		addStep("lru B gone", 0, 32'h048, 32'h0, 1, 0, 32'h0);
		addStep("fill other way", 0, 32'h050, 32'h0, 1, 0, 32'h0);
		addStep("dirty evict", 0, 32'h090, 32'h0, 1, 1, 32'h010);
		addStep("reload dirty", 0, 32'h014, 32'h0, 1, 0, 32'h0);
		repeat (10) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;
		#1;
		checkBit("reset dhit", 1'b0, dhit);
		checkBit("reset dREN", 1'b0, dREN);
		checkBit("reset dWEN", 1'b0, dWEN);
		for (int i = 0; i < numSteps; i++) begin
			runStep(i);
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
cacheCfgPkg.sv
cpuTypesPkg.sv
dcacheWay.sv
dcacheCtrl.sv
dcacheTop.sv
tbMainMemory.sv
dcacheTb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - cacheCfgPkg.sv
  - cpuTypesPkg.sv
  - dcacheWay.sv
  - dcacheCtrl.sv
  - dcacheTop.sv
  - target: simulation
    files:
      - tbMainMemory.sv
      - dcacheTb.sv
